// ==== design/isaPkg.sv ====
// Instruction set definitions for the decode and execute slice
`default_nettype none

package isaPkg;

	// Datapath and field widths
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int OPCODE_W   = 6;
	localparam int SHAMT_W    = 5;
	localparam int FUNCT_W    = 6;
	localparam int IMM_W      = 16;
	localparam int TARGET_W   = 26;

	// Opcodes
	localparam logic [OPCODE_W-1:0] OP_FLUSH = 6'h00;
	localparam logic [OPCODE_W-1:0] OP_LW    = 6'h12;
	localparam logic [OPCODE_W-1:0] OP_LUI   = 6'h0f;
	localparam logic [OPCODE_W-1:0] OP_LBU   = 6'h22;
	localparam logic [OPCODE_W-1:0] OP_SB    = 6'h28;
	localparam logic [OPCODE_W-1:0] OP_SW    = 6'h2b;
	localparam logic [OPCODE_W-1:0] OP_RTYPE = 6'h03;
	localparam logic [OPCODE_W-1:0] OP_ADDI  = 6'h09;
	localparam logic [OPCODE_W-1:0] OP_ANDI  = 6'h0c;
	localparam logic [OPCODE_W-1:0] OP_BEQ   = 6'h05;
	localparam logic [OPCODE_W-1:0] OP_BNE   = 6'h04;
	localparam logic [OPCODE_W-1:0] OP_JAL   = 6'h07;
	localparam logic [OPCODE_W-1:0] OP_J     = 6'h02;
	localparam logic [OPCODE_W-1:0] OP_ORI   = 6'h0e;

	// R-type function codes
	localparam logic [FUNCT_W-1:0] FN_ADD = 6'h20;
	localparam logic [FUNCT_W-1:0] FN_SUB = 6'h22;
	localparam logic [FUNCT_W-1:0] FN_AND = 6'h24;
	localparam logic [FUNCT_W-1:0] FN_OR  = 6'h25;
	localparam logic [FUNCT_W-1:0] FN_SLT = 6'h2a;

	typedef struct packed {
		logic [OPCODE_W-1:0]   opCode;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [REG_ADDR_W-1:0] rd;
		logic [SHAMT_W-1:0]    shamt;
		logic [FUNCT_W-1:0]    funct;
	} rFieldsT;

	typedef struct packed {
		logic [OPCODE_W-1:0]   opCode;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [IMM_W-1:0]      imm;
	} iFieldsT;

	// One instruction word, seen as register or immediate format
	typedef union packed {
		rFieldsT rFields;
		iFieldsT iFields;
	} instrWordT;

endpackage

`default_nettype wire

// ==== design/ctrlPkg.sv ====
// Control definitions shared by the decoder and the execute stage
`default_nettype none

package ctrlPkg;

	// Width of the ALU operation code
	localparam int ALU_OP_W = 4;

	// No operation, result is zero
	localparam logic [ALU_OP_W-1:0] ALU_NONE  = 4'h0;

	// Operation taken from the function field
	localparam logic [ALU_OP_W-1:0] ALU_RTYPE = 4'h2;

	// Bitwise or
	localparam logic [ALU_OP_W-1:0] ALU_OR    = 4'h3;

	// Addition, also used for address generation
	localparam logic [ALU_OP_W-1:0] ALU_ADD   = 4'h4;

	// Bitwise and
	localparam logic [ALU_OP_W-1:0] ALU_AND   = 4'h5;

	// Subtraction, the zero flag drives branches
	localparam logic [ALU_OP_W-1:0] ALU_SUB   = 4'h7;

	// Immediate moved into the upper half
	localparam logic [ALU_OP_W-1:0] ALU_SHL16 = 4'h8;

	// Register written by jump-and-link
	localparam logic [isaPkg::REG_ADDR_W-1:0] LINK_REG = 5'd31;

endpackage

`default_nettype wire

// ==== design/controlUnit.sv ====
// Opcode decoder producing the control levels for one instruction
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
	input  logic [isaPkg::OPCODE_W-1:0]  opCode,
	output logic                         regDst,
	output logic                         regWrite,
	output logic                         memToReg,
	output logic                         jump,
	output logic                         jumpAndLink,
	output logic                         memRead,
	output logic                         memWrite,
	output logic                         branchEqual,
	output logic                         branchNotEqual,
	output logic                         aluSrc,
	output logic                         isSigned,
	output logic [ctrlPkg::ALU_OP_W-1:0] aluOp
);

	import isaPkg::*;
	import ctrlPkg::*;

	always_comb
	begin
		// Everything idle unless the opcode says otherwise
		regDst         = 1'b0;
		regWrite       = 1'b0;
		memToReg       = 1'b0;
		jump           = 1'b0;
		jumpAndLink    = 1'b0;
		memRead        = 1'b0;
		memWrite       = 1'b0;
		branchEqual    = 1'b0;
		branchNotEqual = 1'b0;
		aluSrc         = 1'b0;
		isSigned       = 1'b0;
		aluOp          = ALU_NONE;

		case (opCode)
			OP_LW, OP_LBU:
			begin
				regWrite = 1'b1;
				memToReg = 1'b1;
				memRead  = 1'b1;
				aluSrc   = 1'b1;
				isSigned = 1'b1;
				aluOp    = ALU_ADD;
			end
			OP_LUI:
			begin
				regWrite = 1'b1;
				aluSrc   = 1'b1;
				aluOp    = ALU_SHL16;
			end
			OP_SB, OP_SW:
			begin
				memWrite = 1'b1;
				aluSrc   = 1'b1;
				isSigned = 1'b1;
				aluOp    = ALU_ADD;
			end
			OP_RTYPE:
			begin
				regDst   = 1'b1;
				regWrite = 1'b1;
				aluOp    = ALU_RTYPE;
			end
			OP_ADDI:
			begin
				regWrite = 1'b1;
				aluSrc   = 1'b1;
				// addi sign-extends its immediate
				isSigned = 1'b1;
				aluOp    = ALU_ADD;
			end
			OP_ANDI:
			begin
				regWrite = 1'b1;
				aluSrc   = 1'b1;
				aluOp    = ALU_AND;
			end
			OP_ORI:
			begin
				regWrite = 1'b1;
				aluSrc   = 1'b1;
				aluOp    = ALU_OR;
			end
			OP_BEQ:
			begin
				branchEqual = 1'b1;
				aluOp       = ALU_SUB;
			end
			OP_BNE:
			begin
				branchNotEqual = 1'b1;
				aluOp          = ALU_SUB;
			end
			OP_JAL:
			begin
				jumpAndLink = 1'b1;
				aluOp       = ALU_ADD;
			end
			OP_J:
			begin
				jump  = 1'b1;
				aluOp = ALU_ADD;
			end
			// Flush and unknown opcodes keep the defaults
			default:
			begin
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== design/operandUnit.sv ====
// Register file with two read ports, one write port and immediate extension
`timescale 1ns/1ps
`default_nettype none

module operandUnit (
	input  logic                           clk,
	input  logic                           arstN,
	input  isaPkg::instrWordT              instr,
	input  logic                           isSigned,
	input  logic                           wbEn,
	input  logic [isaPkg::REG_ADDR_W-1:0]  wbReg,
	input  logic [isaPkg::XLEN-1:0]        wbData,
	output logic [isaPkg::XLEN-1:0]        rsData,
	output logic [isaPkg::XLEN-1:0]        rtData,
	output logic [isaPkg::XLEN-1:0]        immExt
);

	import isaPkg::*;

	localparam int NUM_REGS = 2 ** REG_ADDR_W;

	logic [XLEN-1:0] regs [NUM_REGS];
	logic [REG_ADDR_W-1:0] rsIdx;
	logic [REG_ADDR_W-1:0] rtIdx;
	logic [IMM_W-1:0] imm;

	assign rsIdx = instr.iFields.rs;
	assign rtIdx = instr.iFields.rt;
	assign imm   = instr.iFields.imm;

	// Register 0 is never written, so it stays zero after reset
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < NUM_REGS; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wbEn && (wbReg != '0))
		begin
			regs[wbReg] <= wbData;
		end
	end

	// Asynchronous reads
	always_comb
	begin
		rsData = regs[rsIdx];
		rtData = regs[rtIdx];
	end

	// Sign or zero extension of the 16-bit immediate
	always_comb
	begin
		if (isSigned)
		begin
			immExt = {{(XLEN - IMM_W){imm[IMM_W-1]}}, imm};
		end
		else
		begin
			immExt = {{(XLEN - IMM_W){1'b0}}, imm};
		end
	end

endmodule

`default_nettype wire

// ==== design/executeUnit.sv ====
// ALU, branch and jump resolution, write-back request and registered outputs
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
	input  logic                           clk,
	input  logic                           arstN,
	input  isaPkg::instrWordT              instr,
	input  logic [isaPkg::XLEN-1:0]        pc,
	input  logic                           instrValid,
	input  logic                           regDst,
	input  logic                           regWrite,
	input  logic                           memToReg,
	input  logic                           jump,
	input  logic                           jumpAndLink,
	input  logic                           ctlMemRead,
	input  logic                           ctlMemWrite,
	input  logic                           branchEqual,
	input  logic                           branchNotEqual,
	input  logic                           aluSrc,
	input  logic [ctrlPkg::ALU_OP_W-1:0]   aluOp,
	input  logic [isaPkg::XLEN-1:0]        rsData,
	input  logic [isaPkg::XLEN-1:0]        rtData,
	input  logic [isaPkg::XLEN-1:0]        immExt,
	output logic                           wbEn,
	output logic [isaPkg::REG_ADDR_W-1:0]  wbReg,
	output logic [isaPkg::XLEN-1:0]        wbData,
	output logic                           outValid,
	output logic [isaPkg::XLEN-1:0]        result,
	output logic [isaPkg::XLEN-1:0]        storeData,
	output logic [isaPkg::REG_ADDR_W-1:0]  destReg,
	output logic                           regWriteOut,
	output logic                           memRead,
	output logic                           memWrite,
	output logic [isaPkg::XLEN-1:0]        nextPc
);

	import isaPkg::*;
	import ctrlPkg::*;

	logic [XLEN-1:0] aluB;
	logic [XLEN-1:0] aluResult;
	logic            aluZero;
	logic            branchTaken;
	logic [XLEN-1:0] pcPlus4;
	logic [XLEN-1:0] branchTarget;
	logic [XLEN-1:0] jumpTarget;
	logic [XLEN-1:0] pcSel;

	assign aluB = aluSrc ? immExt : rtData;

	always_comb
	begin
		case (aluOp)
			ALU_RTYPE:
			begin
				case (instr.rFields.funct)
					FN_ADD:  aluResult = rsData + aluB;
					FN_SUB:  aluResult = rsData - aluB;
					FN_AND:  aluResult = rsData & aluB;
					FN_OR:   aluResult = rsData | aluB;
					FN_SLT:  aluResult = {{(XLEN - 1){1'b0}}, $signed(rsData) < $signed(aluB)};
					default: aluResult = '0;
				endcase
			end
			ALU_OR:    aluResult = rsData | aluB;
			ALU_ADD:   aluResult = rsData + aluB;
			ALU_AND:   aluResult = rsData & aluB;
			ALU_SUB:   aluResult = rsData - aluB;
			ALU_SHL16: aluResult = immExt << 16;
			default:   aluResult = '0;
		endcase
	end

	assign aluZero     = (aluResult == '0);
	assign branchTaken = (branchEqual && aluZero) || (branchNotEqual && !aluZero);

	// Next PC selection
	assign pcPlus4      = pc + 32'd4;
	assign branchTarget = pcPlus4 + (immExt << 2);
	assign jumpTarget   = {pcPlus4[XLEN-1 -: 4], instr[TARGET_W-1:0], 2'b00};

	always_comb
	begin
		if (jump || jumpAndLink)
		begin
			pcSel = jumpTarget;
		end
		else if (branchTaken)
		begin
			pcSel = branchTarget;
		end
		else
		begin
			pcSel = pcPlus4;
		end
	end

	// Write-back request, loads finish in a later stage
	assign wbEn   = instrValid && ((regWrite && !memToReg) || jumpAndLink);
	assign wbData = jumpAndLink ? pcPlus4 : aluResult;

	always_comb
	begin
		if (regDst)
		begin
			wbReg = instr.rFields.rd;
		end
		else if (jumpAndLink)
		begin
			wbReg = LINK_REG;
		end
		else
		begin
			wbReg = instr.iFields.rt;
		end
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			outValid    <= 1'b0;
			memRead     <= 1'b0;
			memWrite    <= 1'b0;
			regWriteOut <= 1'b0;
			nextPc      <= '0;
		end
		else
		begin
			outValid <= instrValid;
			if (instrValid)
			begin
				memRead     <= ctlMemRead;
				memWrite    <= ctlMemWrite;
				regWriteOut <= wbEn;
				nextPc      <= pcSel;
			end
		end
	end

	// Payload registers
	always_ff @(posedge clk)
	begin
		if (instrValid)
		begin
			result    <= wbData;
			storeData <= rtData;
			destReg   <= wbReg;
		end
	end

endmodule

`default_nettype wire

// ==== design/decodeExecute.sv ====
// Decode and execute slice, decoder plus operand and execute units
`timescale 1ns/1ps
`default_nettype none

module decodeExecute (
	input  logic                           clk,
	input  logic                           arstN,
	input  isaPkg::instrWordT              instr,
	input  logic [isaPkg::XLEN-1:0]        pc,
	input  logic                           instrValid,
	output logic                           outValid,
	output logic [isaPkg::XLEN-1:0]        result,
	output logic [isaPkg::XLEN-1:0]        storeData,
	output logic [isaPkg::REG_ADDR_W-1:0]  destReg,
	output logic                           regWriteOut,
	output logic                           memRead,
	output logic                           memWrite,
	output logic [isaPkg::XLEN-1:0]        nextPc
);

	import isaPkg::*;
	import ctrlPkg::*;

	// Control levels
	logic regDst;
	logic regWrite;
	logic memToReg;
	logic jump;
	logic jumpAndLink;
	logic ctlMemRead;
	logic ctlMemWrite;
	logic branchEqual;
	logic branchNotEqual;
	logic aluSrc;
	logic isSigned;
	logic [ALU_OP_W-1:0] aluOp;

	// Operands and write-back
	logic [XLEN-1:0] rsData;
	logic [XLEN-1:0] rtData;
	logic [XLEN-1:0] immExt;
	logic wbEn;
	logic [REG_ADDR_W-1:0] wbReg;
	logic [XLEN-1:0] wbData;

	controlUnit decoder (
		.opCode(instr.rFields.opCode),
		.regDst(regDst),
		.regWrite(regWrite),
		.memToReg(memToReg),
		.jump(jump),
		.jumpAndLink(jumpAndLink),
		.memRead(ctlMemRead),
		.memWrite(ctlMemWrite),
		.branchEqual(branchEqual),
		.branchNotEqual(branchNotEqual),
		.aluSrc(aluSrc),
		.isSigned(isSigned),
		.aluOp(aluOp)
	);

	operandUnit operands (
		.clk(clk),
		.arstN(arstN),
		.instr(instr),
		.isSigned(isSigned),
		.wbEn(wbEn),
		.wbReg(wbReg),
		.wbData(wbData),
		.rsData(rsData),
		.rtData(rtData),
		.immExt(immExt)
	);

	executeUnit execute (
		.clk(clk),
		.arstN(arstN),
		.instr(instr),
		.pc(pc),
		.instrValid(instrValid),
		.regDst(regDst),
		.regWrite(regWrite),
		.memToReg(memToReg),
		.jump(jump),
		.jumpAndLink(jumpAndLink),
		.ctlMemRead(ctlMemRead),
		.ctlMemWrite(ctlMemWrite),
		.branchEqual(branchEqual),
		.branchNotEqual(branchNotEqual),
		.aluSrc(aluSrc),
		.aluOp(aluOp),
		.rsData(rsData),
		.rtData(rtData),
		.immExt(immExt),
		.wbEn(wbEn),
		.wbReg(wbReg),
		.wbData(wbData),
		.outValid(outValid),
		.result(result),
		.storeData(storeData),
		.destReg(destReg),
		.regWriteOut(regWriteOut),
		.memRead(memRead),
		.memWrite(memWrite),
		.nextPc(nextPc)
	);

endmodule

`default_nettype wire

// ==== tests/decodeExecuteChecker.sv ====
// Scoreboard comparing the slice outputs with queued expectations
`timescale 1ns/1ps
`default_nettype none

module decodeExecuteChecker (
	input  logic                          clk,
	input  logic                          arstN,
	input  logic                          outValid,
	input  logic [isaPkg::XLEN-1:0]       result,
	input  logic [isaPkg::XLEN-1:0]       storeData,
	input  logic [isaPkg::REG_ADDR_W-1:0] destReg,
	input  logic                          regWriteOut,
	input  logic                          memRead,
	input  logic                          memWrite,
	input  logic [isaPkg::XLEN-1:0]       nextPc,
	input  logic                          expValid,
	input  logic [isaPkg::XLEN-1:0]       expResult,
	input  logic [isaPkg::XLEN-1:0]       expStore,
	input  logic [isaPkg::REG_ADDR_W-1:0] expDest,
	input  logic                          expRegWrite,
	input  logic                          expMemRead,
	input  logic                          expMemWrite,
	input  logic [isaPkg::XLEN-1:0]       expNextPc,
	input  logic                          testEnd,
	input  logic [3:0]                    testNum,
	input  logic                          runDone,
	output logic                          idle,
	output int                            errorCount
);

	import isaPkg::*;

	// Result, store data, destination, three strobes and next PC
	logic [3*XLEN+REG_ADDR_W+2:0] expQ [$];
	logic [XLEN-1:0] wantResult;
	logic [XLEN-1:0] wantStore;
	logic [REG_ADDR_W-1:0] wantDest;
	logic wantWrite;
	logic wantRead;
	logic wantMemWrite;
	logic [XLEN-1:0] wantNextPc;
	// Set once a clock edge has passed in reset
	logic resetEdge = 1'b0;
	int errors = 0;
	int testChecks = 0;
	int testErrors = 0;
	int totalChecks = 0;

	assign idle = (expQ.size() == 0);
	assign errorCount = errors;

	task automatic compare(input string what, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] want);
		testChecks++;
		if (got !== want)
		begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, want);
			testErrors++;
			errors++;
		end
	endtask

	// Registered outputs are read before this edge updates them
	always @(posedge clk)
	begin
		if (!arstN)
		begin
			if (resetEdge)
			begin
				compare("outValid in reset", {31'b0, outValid}, '0);
				compare("memRead in reset", {31'b0, memRead}, '0);
				compare("memWrite in reset", {31'b0, memWrite}, '0);
				compare("regWriteOut in reset", {31'b0, regWriteOut}, '0);
				compare("nextPc in reset", nextPc, '0);
			end
			resetEdge = 1'b1;
		end
		else if (outValid)
		begin
			if (expQ.size() == 0)
			begin
				$display("Output valid at %0t with no instruction pending", $time);
				testErrors++;
				errors++;
			end
			else
			begin
				{wantResult, wantStore, wantDest, wantWrite, wantRead, wantMemWrite,
					wantNextPc} = expQ.pop_front();
				compare("result", result, wantResult);
				compare("storeData", storeData, wantStore);
				compare("destReg", {27'b0, destReg}, {27'b0, wantDest});
				compare("regWriteOut", {31'b0, regWriteOut}, {31'b0, wantWrite});
				compare("memRead", {31'b0, memRead}, {31'b0, wantRead});
				compare("memWrite", {31'b0, memWrite}, {31'b0, wantMemWrite});
				compare("nextPc", nextPc, wantNextPc);
			end
		end
		if (expValid)
		begin
			expQ.push_back({expResult, expStore, expDest, expRegWrite, expMemRead,
				expMemWrite, expNextPc});
		end
		if (testEnd)
		begin
			$display("Test %0d done: %0d checks, %0d errors", testNum, testChecks, testErrors);
			totalChecks += testChecks;
			testChecks = 0;
			testErrors = 0;
		end
		if (runDone)
		begin
			$display("Summary: %0d checks, %0d errors", totalChecks, errors);
		end
	end

endmodule

`default_nettype wire

// ==== tests/decodeExecuteTb.sv ====
// Testbench for the decode and execute slice, random instruction streams per test
`timescale 1ns/1ps
`default_nettype none

module decodeExecuteTb;

	import isaPkg::*;
	import ctrlPkg::*;

	// Instructions per test, the cycle limit follows from their sum
	localparam int LOAD_COUNT   = 30;
	localparam int ALU_COUNT    = 28;
	localparam int MEM_COUNT    = 12;
	localparam int BRANCH_COUNT = 8;
	localparam int JUMP_COUNT   = 10;
	localparam int TOTAL_COUNT  = LOAD_COUNT + ALU_COUNT + MEM_COUNT + BRANCH_COUNT + JUMP_COUNT;
	localparam int CYCLE_LIMIT  = 2 * TOTAL_COUNT + 50;

	logic clk;
	logic arstN;
	logic [XLEN-1:0] instr;
	logic [XLEN-1:0] pc;
	logic instrValid;
	logic outValid;
	logic [XLEN-1:0] result;
	logic [XLEN-1:0] storeData;
	logic [REG_ADDR_W-1:0] destReg;
	logic regWriteOut;
	logic memRead;
	logic memWrite;
	logic [XLEN-1:0] nextPc;

	// Expected values for the instruction on the inputs
	logic expValid;
	logic [XLEN-1:0] expResult;
	logic [XLEN-1:0] expStore;
	logic [REG_ADDR_W-1:0] expDest;
	logic expRegWrite;
	logic expMemRead;
	logic expMemWrite;
	logic [XLEN-1:0] expNextPc;

	logic testEnd;
	logic [3:0] testNum;
	logic runDone;
	logic idle;
	int errorCount;
	int cycles = 0;

	logic [XLEN-1:0] shadow [32];
	logic [31:0] rngState;

	decodeExecute DUT (
		.clk(clk), .arstN(arstN), .instr(instr), .pc(pc), .instrValid(instrValid),
		.outValid(outValid), .result(result), .storeData(storeData), .destReg(destReg),
		.regWriteOut(regWriteOut), .memRead(memRead), .memWrite(memWrite), .nextPc(nextPc)
	);

	decodeExecuteChecker scoreboard (
		.clk(clk), .arstN(arstN), .outValid(outValid), .result(result),
		.storeData(storeData), .destReg(destReg), .regWriteOut(regWriteOut),
		.memRead(memRead), .memWrite(memWrite), .nextPc(nextPc),
		.expValid(expValid), .expResult(expResult), .expStore(expStore),
		.expDest(expDest), .expRegWrite(expRegWrite), .expMemRead(expMemRead),
		.expMemWrite(expMemWrite), .expNextPc(expNextPc),
		.testEnd(testEnd), .testNum(testNum), .runDone(runDone),
		.idle(idle), .errorCount(errorCount)
	);

	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TESTS FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] nextRand();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	// Word aligned random program counter
	function automatic logic [31:0] randPc();
		logic [31:0] v;
		v = nextRand();
		return {v[31:2], 2'b00};
	endfunction

	function automatic logic [31:0] rWord(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jumpWord(input logic [5:0] op, input logic [25:0] target);
		return {op, target};
	endfunction

	// Expected slice outputs for one instruction, shadow registers follow the writes
	function automatic void expectOut(input logic [31:0] word, input logic [31:0] pcIn);
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [31:0] sext;
		logic [31:0] zext;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] pc4;
		logic [31:0] jumpTo;
		op = word[31:26];
		rs = word[25:21];
		rt = word[20:16];
		sext = {{16{word[15]}}, word[15:0]};
		zext = {16'h0000, word[15:0]};
		a = shadow[rs];
		b = shadow[rt];
		pc4 = pcIn + 32'd4;
		jumpTo = {pc4[31:28], word[25:0], 2'b00};
		expResult = '0;
		expStore = b;
		expDest = rt;
		expRegWrite = 1'b0;
		expMemRead = 1'b0;
		expMemWrite = 1'b0;
		expNextPc = pc4;
		case (op)
			OP_LW, OP_LBU:
			begin
				expResult = a + sext;
				expMemRead = 1'b1;
			end
			OP_SB, OP_SW:
			begin
				expResult = a + sext;
				expMemWrite = 1'b1;
			end
			OP_LUI:
			begin
				expResult = {word[15:0], 16'h0000};
				expRegWrite = 1'b1;
			end
			OP_RTYPE:
			begin
				expDest = word[15:11];
				expRegWrite = 1'b1;
				case (word[5:0])
					FN_ADD:  expResult = a + b;
					FN_SUB:  expResult = a - b;
					FN_AND:  expResult = a & b;
					FN_OR:   expResult = a | b;
					FN_SLT:  expResult = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: expResult = '0;
				endcase
			end
			OP_ADDI:
			begin
				expResult = a + sext;
				expRegWrite = 1'b1;
			end
			OP_ANDI:
			begin
				expResult = a & zext;
				expRegWrite = 1'b1;
			end
			OP_ORI:
			begin
				expResult = a | zext;
				expRegWrite = 1'b1;
			end
			// Branch offsets here use the zero-extended immediate
			OP_BEQ:
			begin
				expResult = a - b;
				if (a == b)
				begin
					expNextPc = pc4 + (zext << 2);
				end
			end
			OP_BNE:
			begin
				expResult = a - b;
				if (a != b)
				begin
					expNextPc = pc4 + (zext << 2);
				end
			end
			OP_JAL:
			begin
				expResult = pc4;
				expDest = LINK_REG;
				expRegWrite = 1'b1;
				expNextPc = jumpTo;
			end
			OP_J:
			begin
				expResult = a + b;
				expNextPc = jumpTo;
			end
			default:
			begin
			end
		endcase
		if (expRegWrite && (expDest != 5'd0))
		begin
			shadow[expDest] = expResult;
		end
	endfunction

	task automatic issue(input logic [31:0] word, input logic [31:0] pcIn);
		@(negedge clk);
		instr = word;
		pc = pcIn;
		instrValid = 1'b1;
		expectOut(word, pcIn);
		expValid = 1'b1;
	endtask

	// Drain the pipeline, then let the checker report the test
	task automatic finishTest(input logic [3:0] num);
		@(negedge clk);
		instrValid = 1'b0;
		expValid = 1'b0;
		@(negedge clk);
		while (!idle)
		begin
			@(negedge clk);
		end
		testNum = num;
		testEnd = 1'b1;
		@(negedge clk);
		testEnd = 1'b0;
	endtask

	initial
	begin
		logic [31:0] r;
		logic [31:0] w;
		logic [4:0] rtSel;
		rngState = 32'hf50c;
		clk = 1'b0;
		arstN = 1'b0;
		instr = '0;
		pc = '0;
		instrValid = 1'b0;
		expValid = 1'b0;
		expResult = '0;
		expStore = '0;
		expDest = '0;
		expRegWrite = 1'b0;
		expMemRead = 1'b0;
		expMemWrite = 1'b0;
		expNextPc = '0;
		testEnd = 1'b0;
		testNum = '0;
		runDone = 1'b0;
		for (int k = 0; k < 32; k++)
		begin
			shadow[k] = '0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;

		// Fill registers from register 0 with signed immediates
		for (int i = 1; i <= LOAD_COUNT; i++)
		begin
			r = nextRand();
			issue(iWord(OP_ADDI, 5'd0, 5'(i), r[15:0]), randPc());
		end
		finishTest(4'd1);

		for (int i = 0; i < ALU_COUNT; i++)
		begin
			r = nextRand();
			case (i % 7)
				0:       w = rWord(FN_ADD, r[4:0], r[9:5], r[14:10]);
				1:       w = rWord(FN_SUB, r[4:0], r[9:5], r[14:10]);
				2:       w = rWord(FN_AND, r[4:0], r[9:5], r[14:10]);
				3:       w = rWord(FN_OR, r[4:0], r[9:5], r[14:10]);
				4:       w = rWord(FN_SLT, r[4:0], r[9:5], r[14:10]);
				5:       w = iWord(OP_ANDI, r[4:0], r[9:5], r[31:16]);
				default: w = iWord(OP_ORI, r[4:0], r[9:5], r[31:16]);
			endcase
			issue(w, randPc());
		end
		finishTest(4'd2);

		for (int i = 0; i < MEM_COUNT; i++)
		begin
			r = nextRand();
			case (i % 3)
				0:       w = iWord(OP_LUI, r[4:0], r[9:5], r[31:16]);
				1:       w = iWord(r[20] ? OP_LW : OP_LBU, r[4:0], r[9:5], r[31:16]);
				default: w = iWord(r[20] ? OP_SW : OP_SB, r[4:0], r[9:5], r[31:16]);
			endcase
			issue(w, randPc());
		end
		finishTest(4'd3);

		// Even steps compare a register with itself
		for (int i = 0; i < BRANCH_COUNT; i++)
		begin
			r = nextRand();
			rtSel = i[0] ? r[9:5] : r[4:0];
			w = iWord((i < 4) ? OP_BEQ : OP_BNE, r[4:0], rtSel, {1'b0, r[30:16]});
			issue(w, randPc());
		end
		finishTest(4'd4);

		for (int k = 0; k < 2; k++)
		begin
			r = nextRand();
			issue(jumpWord(OP_J, r[25:0]), randPc());
			r = nextRand();
			issue(jumpWord(OP_JAL, r[25:0]), randPc());
			// Read the link register back
			issue(rWord(FN_ADD, LINK_REG, 5'd0, {1'b0, r[3:0]} + 5'd1), randPc());
			r = nextRand();
			issue(iWord(OP_FLUSH, r[4:0], r[9:5], r[31:16]), randPc());
			r = nextRand();
			issue(iWord((k == 0) ? 6'h01 : 6'h3f, r[4:0], r[9:5], r[31:16]), randPc());
		end
		finishTest(4'd5);

		runDone = 1'b1;
		@(negedge clk);
		runDone = 1'b0;
		if (errorCount == 0)
		begin
			$display("TESTS PASSED");
		end
		else
		begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== decodeExecute.f ====
design/isaPkg.sv
design/ctrlPkg.sv
design/controlUnit.sv
design/operandUnit.sv
design/executeUnit.sv
design/decodeExecute.sv
tests/decodeExecuteChecker.sv
tests/decodeExecuteTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the decode and execute testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module decodeExecuteTb -f decodeExecute.f -o simv \
	&& ./obj_dir/simv > sim.log 2>&1 \
	|| echo "Build or simulation ended with an error"

cat sim.log 2>/dev/null

grep -qx "TESTS PASSED" sim.log \
	&& echo "Result: pass" \
	|| { echo "Result: fail"; exit 1; }
exit 0
